// File: bus_pkg.sv
//######################################################################
// Shared Wishbone bus types for the fabric
// Request and reply bundles plus the arbiter state encoding
//######################################################################
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;   // One select bit per byte lane

    // Manager to target, held steady until ack
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
    } wb_req_t;

    // Target to manager
    typedef struct packed {
        logic              ack;   // Single-cycle pulse
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

endpackage

`default_nettype wire

// File: map_pkg.sv
//######################################################################
// Fabric address map and pad mux constants
//######################################################################
`default_nettype none

package map_pkg;

    // Region field sits in adr[15:12]
    localparam int REGION_LSB = 12;
    localparam int REGION_W   = 4;

    typedef enum logic [1:0] {
        REGION_RAM    = 2'd0,
        REGION_PINMUX = 2'd1,
        REGION_NONE   = 2'd2   // Anything else on the region field
    } region_e;

    localparam int NUM_PADS  = 38;
    localparam int PAD_SEL_W = 4;

    // Select value that parks a pad (out 0, oeb 1)
    localparam logic [PAD_SEL_W-1:0] PAD_OFF = 4'hF;

endpackage

`default_nettype wire

// File: reset_sync.sv
//######################################################################
// Reset synchronizer, asserts at once and releases after two clocks
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module reset_sync (
    input  wire  clk,
    input  wire  asyncrst_n,
    output logic rst_n_o
);

    logic meta_q;   // First stage, may go metastable on release

    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            meta_q  <= 1'b0;
            rst_n_o <= 1'b0;
        end else begin
            meta_q  <= 1'b1;
            rst_n_o <= meta_q;
        end
    end

endmodule

`default_nettype wire

// File: wb_arbiter.sv
//######################################################################
// Round-robin Wishbone arbiter from many managers onto one shared bus
// Grant is held for as long as the winner keeps cyc high
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter #(
    parameter int NUM_TEAMS = 4
) (
    input  wire              clk,
    input  wire              rst_n_i,
    input  bus_pkg::wb_req_t mgr_req_i [NUM_TEAMS+1],
    output bus_pkg::wb_rsp_t mgr_rsp_o [NUM_TEAMS+1],
    output bus_pkg::wb_req_t bus_req_o,
    input  bus_pkg::wb_rsp_t bus_rsp_i
);

    localparam int NUM_MGR = NUM_TEAMS + 1;   // Host plus teams
    localparam int IDX_W   = $clog2(NUM_MGR);

    bus_pkg::arb_state_e state_q;
    logic [IDX_W-1:0]    grant_q;    // Current or last granted manager
    logic [IDX_W-1:0]    next_idx;
    logic                found;

    // Search for the next requester starting just past the last grant
    always_comb begin
        int cand;
        next_idx = grant_q;
        found    = 1'b0;
        for (int i = 1; i <= NUM_MGR; i++) begin
            cand = (int'(grant_q) + i) % NUM_MGR;
            if (!found && mgr_req_i[cand].cyc) begin
                found    = 1'b1;
                next_idx = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= bus_pkg::ARB_IDLE;
            grant_q <= IDX_W'(NUM_MGR - 1);   // Host wins the first round
        end else begin
            case (state_q)
                bus_pkg::ARB_IDLE: begin
                    if (found) begin
                        state_q <= bus_pkg::ARB_BUSY;
                        grant_q <= next_idx;
                    end
                end
                bus_pkg::ARB_BUSY: begin
                    if (!mgr_req_i[grant_q].cyc) state_q <= bus_pkg::ARB_IDLE;
                end
                default: state_q <= bus_pkg::ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        bus_req_o = mgr_req_i[grant_q];
        if (state_q != bus_pkg::ARB_BUSY) begin
            bus_req_o.cyc = 1'b0;   // Nobody owns the bus yet
            bus_req_o.stb = 1'b0;
        end
    end

    // Only the owner sees the reply and the rest keep waiting
    always_comb begin
        for (int m = 0; m < NUM_MGR; m++) begin
            mgr_rsp_o[m] = '0;
            if (state_q == bus_pkg::ARB_BUSY && grant_q == IDX_W'(m)) begin
                mgr_rsp_o[m] = bus_rsp_i;
            end
        end
    end

    // A reply must find its owner still holding the cycle
    a_ack_reaches_owner : assert property (@(posedge clk) disable iff (!rst_n_i)
        bus_rsp_i.ack |-> (state_q == bus_pkg::ARB_BUSY && mgr_req_i[grant_q].cyc));

endmodule

`default_nettype wire

// File: wb_decoder.sv
//######################################################################
// Address decoder, steers the shared bus to RAM or pin mux
// Unmapped accesses get an ack with zero data
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module wb_decoder (
    input  wire              clk,
    input  wire              rst_n_i,
    input  bus_pkg::wb_req_t bus_req_i,
    output bus_pkg::wb_rsp_t bus_rsp_o,
    output bus_pkg::wb_req_t ram_req_o,
    input  bus_pkg::wb_rsp_t ram_rsp_i,
    output bus_pkg::wb_req_t pinmux_req_o,
    input  bus_pkg::wb_rsp_t pinmux_rsp_i
);

    map_pkg::region_e region;
    logic             none_ack_q;   // Ack for the unmapped responder
    logic             req_valid;

    assign req_valid = bus_req_i.cyc && bus_req_i.stb;

    always_comb begin
        case (bus_req_i.adr[map_pkg::REGION_LSB +: map_pkg::REGION_W])
            0:       region = map_pkg::REGION_RAM;
            1:       region = map_pkg::REGION_PINMUX;
            default: region = map_pkg::REGION_NONE;
        endcase
    end

    // Payload fans out everywhere, only cyc and stb are steered
    always_comb begin
        ram_req_o        = bus_req_i;
        pinmux_req_o     = bus_req_i;
        ram_req_o.cyc    = bus_req_i.cyc && (region == map_pkg::REGION_RAM);
        ram_req_o.stb    = bus_req_i.stb && (region == map_pkg::REGION_RAM);
        pinmux_req_o.cyc = bus_req_i.cyc && (region == map_pkg::REGION_PINMUX);
        pinmux_req_o.stb = bus_req_i.stb && (region == map_pkg::REGION_PINMUX);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) none_ack_q <= 1'b0;
        else none_ack_q <= req_valid && (region == map_pkg::REGION_NONE) && !none_ack_q;
    end

    always_comb begin
        case (region)
            map_pkg::REGION_RAM:    bus_rsp_o = ram_rsp_i;
            map_pkg::REGION_PINMUX: bus_rsp_o = pinmux_rsp_i;
            default: begin
                bus_rsp_o.ack = none_ack_q;
                bus_rsp_o.dat = '0;
            end
        endcase
    end

    a_one_target_ack : assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({ram_rsp_i.ack, pinmux_rsp_i.ack, none_ack_q}));

endmodule

`default_nettype wire

// File: wb_ram.sv
//######################################################################
// Flip-flop word RAM on Wishbone with byte-select writes
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module wb_ram #(
    parameter int RAM_WORDS = 64
) (
    input  wire              clk,
    input  wire              rst_n_i,
    input  bus_pkg::wb_req_t req_i,
    output bus_pkg::wb_rsp_t rsp_o
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [bus_pkg::DATA_W-1:0] mem [RAM_WORDS];
    logic [bus_pkg::DATA_W-1:0] rdata_q;
    logic [AW-1:0]              idx;
    logic                       ack_q;
    logic                       access;

    // Word index wraps within the region
    assign idx    = req_i.adr[2 +: AW];
    assign access = req_i.cyc && req_i.stb && !ack_q;   // Once per transfer

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) ack_q <= 1'b0;
        else ack_q <= access;
    end

    always_ff @(posedge clk) begin
        if (access && req_i.we) begin
            for (int b = 0; b < bus_pkg::SEL_W; b++) begin
                if (req_i.sel[b]) mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
        end
        if (access) rdata_q <= mem[idx];
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

// File: pin_mux.sv
//######################################################################
// Pad multiplexer, a select register per pad picks the driving team
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module pin_mux #(
    parameter int NUM_TEAMS = 4
) (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  bus_pkg::wb_req_t             req_i,
    output bus_pkg::wb_rsp_t             rsp_o,
    input  wire [map_pkg::NUM_PADS-1:0]  team_out_i [NUM_TEAMS],
    input  wire [map_pkg::NUM_PADS-1:0]  team_oeb_i [NUM_TEAMS],
    output logic [map_pkg::NUM_PADS-1:0] io_out_o,
    output logic [map_pkg::NUM_PADS-1:0] io_oeb_o
);

    localparam int PAD_IDX_W = $clog2(map_pkg::NUM_PADS);

    logic [map_pkg::PAD_SEL_W-1:0] sel_q [map_pkg::NUM_PADS];
    logic [bus_pkg::DATA_W-1:0]    rdata_q;
    logic [map_pkg::REGION_LSB-3:0] offset;    // Word offset in the region
    logic [PAD_IDX_W-1:0]          pad_idx;
    logic                          pad_hit;
    logic                          access;
    logic                          ack_q;

    assign offset  = req_i.adr[map_pkg::REGION_LSB-1:2];
    assign pad_hit = offset < map_pkg::NUM_PADS;
    assign pad_idx = offset[PAD_IDX_W-1:0];
    assign access  = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            for (int p = 0; p < map_pkg::NUM_PADS; p++) sel_q[p] <= map_pkg::PAD_OFF;
        end else begin
            ack_q <= access;
            if (access && req_i.we && req_i.sel[0] && pad_hit) begin
                sel_q[pad_idx] <= req_i.dat[map_pkg::PAD_SEL_W-1:0];
            end
        end
    end

    // Read data, holes read as zero
    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= '0;
            if (pad_hit) rdata_q[map_pkg::PAD_SEL_W-1:0] <= sel_q[pad_idx];
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

    // Pad drive
    always_comb begin
        for (int p = 0; p < map_pkg::NUM_PADS; p++) begin
            io_out_o[p] = 1'b0;
            io_oeb_o[p] = 1'b1;   // Parked as input unless a team owns it
            for (int t = 0; t < NUM_TEAMS; t++) begin
                if (sel_q[p] == map_pkg::PAD_SEL_W'(t)) begin
                    io_out_o[p] = team_out_i[t][p];
                    io_oeb_o[p] = team_oeb_i[t][p];
                end
            end
        end
    end

    a_ack_needs_stb : assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_o.ack |-> req_i.stb);

endmodule

`default_nettype wire

// File: fabric_top.sv
//######################################################################
// Bus fabric top, host and teams share RAM and pad mux over Wishbone
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module fabric_top #(
    parameter int NUM_TEAMS = 4,
    parameter int RAM_WORDS = 64
) (
    input  wire                          clk,
    input  wire                          asyncrst_n,
    input  bus_pkg::wb_req_t             host_req_i,
    output bus_pkg::wb_rsp_t             host_rsp_o,
    input  bus_pkg::wb_req_t             team_req_i [NUM_TEAMS],
    output bus_pkg::wb_rsp_t             team_rsp_o [NUM_TEAMS],
    input  wire [map_pkg::NUM_PADS-1:0]  team_out_i [NUM_TEAMS],
    input  wire [map_pkg::NUM_PADS-1:0]  team_oeb_i [NUM_TEAMS],
    output logic [map_pkg::NUM_PADS-1:0] io_out_o,
    output logic [map_pkg::NUM_PADS-1:0] io_oeb_o,
    output logic                         team_rst_n_o
);

    logic             sys_rst_n;
    bus_pkg::wb_req_t mgr_req [NUM_TEAMS+1];
    bus_pkg::wb_rsp_t mgr_rsp [NUM_TEAMS+1];
    bus_pkg::wb_req_t bus_req;
    bus_pkg::wb_rsp_t bus_rsp;
    bus_pkg::wb_req_t ram_req;
    bus_pkg::wb_rsp_t ram_rsp;
    bus_pkg::wb_req_t pinmux_req;
    bus_pkg::wb_rsp_t pinmux_rsp;

    // Host is manager 0, team k is manager k+1
    assign mgr_req[0]   = host_req_i;
    assign host_rsp_o   = mgr_rsp[0];
    assign team_rst_n_o = sys_rst_n;   // Teams share the fabric reset

    for (genvar k = 0; k < NUM_TEAMS; k++) begin : g_team
        assign mgr_req[k+1] = team_req_i[k];
        assign team_rsp_o[k] = mgr_rsp[k+1];
    end

    reset_sync i_reset_sync (
        .clk        (clk),
        .asyncrst_n (asyncrst_n),
        .rst_n_o    (sys_rst_n)
    );

    wb_arbiter #(.NUM_TEAMS(NUM_TEAMS)) i_wb_arbiter (
        .clk       (clk),
        .rst_n_i   (sys_rst_n),
        .mgr_req_i (mgr_req),
        .mgr_rsp_o (mgr_rsp),
        .bus_req_o (bus_req),
        .bus_rsp_i (bus_rsp)
    );

    wb_decoder i_wb_decoder (
        .clk          (clk),
        .rst_n_i      (sys_rst_n),
        .bus_req_i    (bus_req),
        .bus_rsp_o    (bus_rsp),
        .ram_req_o    (ram_req),
        .ram_rsp_i    (ram_rsp),
        .pinmux_req_o (pinmux_req),
        .pinmux_rsp_i (pinmux_rsp)
    );

    wb_ram #(.RAM_WORDS(RAM_WORDS)) i_wb_ram (
        .clk     (clk),
        .rst_n_i (sys_rst_n),
        .req_i   (ram_req),
        .rsp_o   (ram_rsp)
    );

    pin_mux #(.NUM_TEAMS(NUM_TEAMS)) i_pin_mux (
        .clk        (clk),
        .rst_n_i    (sys_rst_n),
        .req_i      (pinmux_req),
        .rsp_o      (pinmux_rsp),
        .team_out_i (team_out_i),
        .team_oeb_i (team_oeb_i),
        .io_out_o   (io_out_o),
        .io_oeb_o   (io_oeb_o)
    );

endmodule

`default_nettype wire

// File: tb_checker.sv
//######################################################################
// Testbench monitor, compares DUT outputs with model values
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
    parameter int NUM_MGR = 5
) (
    input  wire                          clk,
    input  wire                          pad_chk_en_i,
    input  wire                          rst_chk_en_i,
    input  wire                          team_rst_n_i,
    input  wire [map_pkg::NUM_PADS-1:0]  io_out_i,
    input  wire [map_pkg::NUM_PADS-1:0]  io_oeb_i,
    input  wire [map_pkg::NUM_PADS-1:0]  exp_out_i,
    input  wire [map_pkg::NUM_PADS-1:0]  exp_oeb_i,
    input  bus_pkg::wb_req_t             mgr_req_i [NUM_MGR],
    input  bus_pkg::wb_rsp_t             mgr_rsp_i [NUM_MGR],
    output int                           err_cnt_o
);

    int errors = 0;

    assign err_cnt_o = errors;

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %s at %0t", msg, $time);
    endtask

    // Pads compared against the model every cycle while enabled
    always @(posedge clk) begin
        if (pad_chk_en_i) begin
            check_val("io_out_o", 64'(io_out_i), 64'(exp_out_i));
            check_val("io_oeb_o", 64'(io_oeb_i), 64'(exp_oeb_i));
        end
        if (rst_chk_en_i && !team_rst_n_i) begin
            report_error("team reset went low after it had been released");
        end
    end

    // An ack outside a held request would be a second or stray ack
    always @(negedge clk) begin
        for (int m = 0; m < NUM_MGR; m++) begin
            if (mgr_rsp_i[m].ack && !mgr_req_i[m].cyc) begin
                report_error($sformatf("manager %0d saw an ack with no request open", m));
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_top.sv
//######################################################################
// Testbench for the bus fabric with LFSR stimulus and a reference model
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk_o
);
    initial clk_o = 1'b0;
    always #10 clk_o = ~clk_o;   // 20 ns period
endmodule

module tb_top;

    localparam int NUM_TEAMS     = 4;
    localparam int NUM_MGR       = NUM_TEAMS + 1;
    localparam int RAM_WORDS     = 64;
    localparam int WORDS_PER_MGR = 12;   // Disjoint RAM range per manager
    localparam int ACC_PER_MGR   = 12;
    localparam int NUM_PADS      = map_pkg::NUM_PADS;
    localparam int NUM_ACCESSES  = 18 + NUM_MGR * ACC_PER_MGR + 2 * NUM_PADS + 5;
    localparam int TIMEOUT       = NUM_ACCESSES * 20;

    logic                clk;
    logic                asyncrst_n;
    bus_pkg::wb_req_t    mgr_req [NUM_MGR];
    bus_pkg::wb_rsp_t    mgr_rsp [NUM_MGR];
    bus_pkg::wb_req_t    team_req [NUM_TEAMS];
    bus_pkg::wb_rsp_t    team_rsp [NUM_TEAMS];
    bus_pkg::wb_rsp_t    host_rsp;
    logic [NUM_PADS-1:0] team_out [NUM_TEAMS];
    logic [NUM_PADS-1:0] team_oeb [NUM_TEAMS];
    logic [NUM_PADS-1:0] io_out;
    logic [NUM_PADS-1:0] io_oeb;
    logic                team_rst_n;
    logic [NUM_PADS-1:0] exp_out;
    logic [NUM_PADS-1:0] exp_oeb;
    logic                pad_chk_en;
    logic                rst_chk_en;
    int                  err_cnt;
    int                  cycle_cnt;

    logic [31:0] lfsr_q;
    logic [31:0] model_mem [RAM_WORDS];
    bit          written [RAM_WORDS];
    logic [3:0]  model_sel [NUM_PADS];

    assign mgr_rsp[0] = host_rsp;
    for (genvar k = 0; k < NUM_TEAMS; k++) begin : g_mgr
        assign team_req[k]  = mgr_req[k+1];
        assign mgr_rsp[k+1] = team_rsp[k];
    end

    tb_clock i_tb_clock (.clk_o(clk));

    fabric_top #(.NUM_TEAMS(NUM_TEAMS), .RAM_WORDS(RAM_WORDS)) i_fabric_top (
        .clk          (clk),
        .asyncrst_n   (asyncrst_n),
        .host_req_i   (mgr_req[0]),
        .host_rsp_o   (host_rsp),
        .team_req_i   (team_req),
        .team_rsp_o   (team_rsp),
        .team_out_i   (team_out),
        .team_oeb_i   (team_oeb),
        .io_out_o     (io_out),
        .io_oeb_o     (io_oeb),
        .team_rst_n_o (team_rst_n)
    );

    tb_checker #(.NUM_MGR(NUM_MGR)) i_tb_checker (
        .clk          (clk),
        .pad_chk_en_i (pad_chk_en),
        .rst_chk_en_i (rst_chk_en),
        .team_rst_n_i (team_rst_n),
        .io_out_i     (io_out),
        .io_oeb_i     (io_oeb),
        .exp_out_i    (exp_out),
        .exp_oeb_i    (exp_oeb),
        .mgr_req_i    (mgr_req),
        .mgr_rsp_i    (mgr_rsp),
        .err_cnt_o    (err_cnt)
    );

    // A team index drives the pad and any other select parks it
    always_comb begin
        exp_out = '0;
        exp_oeb = '1;
        for (int p = 0; p < NUM_PADS; p++) begin
            if (model_sel[p] < NUM_TEAMS) begin
                exp_out[p] = team_out[model_sel[p]][p];
                exp_oeb[p] = team_oeb[model_sel[p]][p];
            end
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [63:0] next_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  sel);
        logic [31:0] r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) r[8*b +: 8] = new_w[8*b +: 8];
        end
        return r;
    endfunction

    // One classic Wishbone transfer that returns data and cycles before ack
    task automatic wb_access(input int m, input logic we, input logic [31:0] adr,
                             input logic [31:0] wdat, input logic [3:0] sel,
                             output logic [31:0] rdat, output int wait_cyc);
        bus_pkg::wb_req_t req;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdat;
        req.sel = sel;
        @(posedge clk);
        mgr_req[m] <= req;
        wait_cyc = 0;
        @(negedge clk);
        while (!mgr_rsp[m].ack) begin
            wait_cyc++;
            @(negedge clk);
        end
        rdat = mgr_rsp[m].dat;
        @(posedge clk);
        mgr_req[m] <= '0;
    endtask

    task automatic ram_write(input int m, input int w, input logic [31:0] d,
                             input logic [3:0] s, output int wait_cyc);
        logic [31:0] rd;
        model_mem[w] = merge_bytes(model_mem[w], d, s);
        written[w]   = 1'b1;
        wb_access(m, 1'b1, 32'(w) << 2, d, s, rd, wait_cyc);
    endtask

    task automatic ram_read_check(input int m, input int w, output int wait_cyc);
        logic [31:0] rd;
        wb_access(m, 1'b0, 32'(w) << 2, '0, 4'hF, rd, wait_cyc);
        i_tb_checker.check_val("ram rdata", 64'(rd), 64'(model_mem[w]));
    endtask

    // Random traffic of one manager inside its own word range
    task automatic run_traffic(input int m);
        int          w;
        int          lat;
        logic [63:0] r;
        logic [3:0]  s;
        for (int i = 0; i < ACC_PER_MGR; i++) begin
            w = m * WORDS_PER_MGR + int'(next_bits(8)) % WORDS_PER_MGR;
            r = next_bits(1);
            if (r[0] || !written[w]) begin
                s = 4'(next_bits(4));
                if (!written[w]) s = 4'hF;
                ram_write(m, w, 32'(next_bits(32)), s, lat);
            end else begin
                ram_read_check(m, w, lat);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT) begin
            $display("Run timed out after %0d cycles with accesses still pending", cycle_cnt);
            $display("Errors: %0d", err_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int          lat;
        int          w;
        logic [31:0] rd;
        logic [3:0]  s;
        lfsr_q     = 32'h784;
        cycle_cnt  = 0;
        asyncrst_n = 1'b0;
        pad_chk_en = 1'b0;
        rst_chk_en = 1'b0;
        for (int m = 0; m < NUM_MGR; m++) mgr_req[m] = '0;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            team_out[t] = '0;
            team_oeb[t] = '0;
        end
        for (int p = 0; p < NUM_PADS; p++) model_sel[p] = 4'hF;
        for (int i = 0; i < RAM_WORDS; i++) written[i] = 1'b0;

        // Reset held for 10 cycles and released on a rising edge
        repeat (10) begin
            @(negedge clk);
            i_tb_checker.check_val("team_rst_n_o", 64'(team_rst_n), 64'd0);
            i_tb_checker.check_val("io_oeb_o", 64'(io_oeb), 64'({NUM_PADS{1'b1}}));
        end
        @(posedge clk);
        asyncrst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            i_tb_checker.check_val("team_rst_n_o", 64'(team_rst_n), 64'd0);
            i_tb_checker.check_val("io_oeb_o", 64'(io_oeb), 64'({NUM_PADS{1'b1}}));
        end
        @(negedge clk);
        i_tb_checker.check_val("team_rst_n_o", 64'(team_rst_n), 64'd1);
        @(posedge clk);
        rst_chk_en <= 1'b1;

        // Host alone checks fixed latency and byte merge
        for (int i = 0; i < 6; i++) begin
            w = int'(next_bits(8)) % WORDS_PER_MGR;
            ram_write(0, w, 32'(next_bits(32)), 4'hF, lat);
            i_tb_checker.check_val("host ack latency", 64'(lat), 64'd2);
            s = 4'(next_bits(4));
            ram_write(0, w, 32'(next_bits(32)), s, lat);
            i_tb_checker.check_val("host ack latency", 64'(lat), 64'd2);
            ram_read_check(0, w, lat);
            i_tb_checker.check_val("host ack latency", 64'(lat), 64'd2);
        end

        // All managers at once
        fork
            run_traffic(0);
            run_traffic(1);
            run_traffic(2);
            run_traffic(3);
            run_traffic(4);
        join

        // Pad selects first and then random team drive
        for (int p = 0; p < NUM_PADS; p++) begin
            s = 4'(next_bits(4));
            if (next_bits(2) == 0) s = 4'hF;
            model_sel[p] = s;
            wb_access(0, 1'b1, 32'h1000 | (32'(p) << 2), 32'(s), 4'h1, rd, lat);
        end
        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            for (int t = 0; t < NUM_TEAMS; t++) begin
                team_out[t] <= NUM_PADS'(next_bits(NUM_PADS));
                team_oeb[t] <= NUM_PADS'(next_bits(NUM_PADS));
            end
            pad_chk_en <= 1'b1;
            repeat (3) @(posedge clk);
        end
        pad_chk_en <= 1'b0;

        // Unmapped reads and pin-mux read-back
        for (int i = 0; i < 4; i++) begin
            w = 2 + int'(next_bits(8)) % 14;
            wb_access(0, 1'b0, 32'(w) << 12, '0, 4'hF, rd, lat);
            i_tb_checker.check_val("unmapped rdata", 64'(rd), 64'd0);
        end
        for (int p = 0; p < NUM_PADS; p++) begin
            wb_access(0, 1'b0, 32'h1000 | (32'(p) << 2), '0, 4'hF, rd, lat);
            i_tb_checker.check_val("pad select rdata", 64'(rd), 64'(model_sel[p]));
        end
        wb_access(0, 1'b0, 32'h1000 | (32'(NUM_PADS) << 2), '0, 4'hF, rd, lat);
        i_tb_checker.check_val("pin-mux hole rdata", 64'(rd), 64'd0);

        repeat (2) @(posedge clk);
        $display("Errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
bus_pkg.sv
map_pkg.sv
reset_sync.sv
wb_arbiter.sv
wb_decoder.sv
wb_ram.sv
pin_mux.sv
fabric_top.sv
tb_checker.sv
tb_top.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_top
FILELIST := project.f
BIN      := obj_dir/V$(TOP)
PASS_MSG := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
